//--- kyber_consts.svh
// fixed Kyber parameters only (q = 3329, n = 256); changing them needs a new zeta table
`ifndef KYBER_CONSTS_SVH
`define KYBER_CONSTS_SVH

// modulus and ring size
`define KYBER_Q 3329
`define KYBER_N 256

// coefficient width, two coefficients per RAM word
`define KYBER_POLY_WIDTH 16

// q^-1 mod 2^16, signed
`define KYBER_QINV (-3327)

// storage and iteration counts
`define KYBER_WORDS (`KYBER_N / 2)
`define KYBER_ITER (`KYBER_WORDS / 2)

// pipeline latencies in clock cycles
`define KYBER_FQMUL_LAT 2
`define KYBER_BASEMUL_LAT 4

// start sampled in cycle 0, done pulses in this cycle
`define KYBER_RUN_LAT 70

`endif

//--- kyber_pkg.sv
// coefficients are signed 16-bit and kept in Montgomery-friendly range, never fully reduced
`include "kyber_consts.svh"

package kyber_pkg;

  // one coefficient, roughly within (-2q, 2q)
  typedef logic signed [`KYBER_POLY_WIDTH-1:0] coeff_t;

  // full product of two coefficients before reduction
  typedef logic signed [2*`KYBER_POLY_WIDTH-1:0] prod_t;

  // lo is the even coefficient 2k, hi the odd one 2k+1
  typedef struct packed {
    coeff_t hi;
    coeff_t lo;
  } coeff_pair_t;

  // one RAM word; host side uses raw, datapath uses pair
  typedef union packed {
    logic [2*`KYBER_POLY_WIDTH-1:0] raw;
    coeff_pair_t                    pair;
  } coeff_pair_u;

endpackage

//--- rom_zetas.sv
// constant Kyber zeta table in Montgomery form, centred values, one cycle read latency
`include "kyber_consts.svh"

module rom_zetas (
  input  logic              clk,
  input  logic [6:0]        addr,
  output kyber_pkg::coeff_t zeta
);

  import kyber_pkg::*;

  // zeta[k] = 17^brv7(k) * 2^16 mod q, centred into (-q/2, q/2]
  // entry 0 is just the Montgomery factor 2^16 mod q
  localparam coeff_t zeta_table [`KYBER_WORDS] = '{
    -1044,  -758,  -359, -1517,  1493,  1422,   287,   202,
     -171,   622,  1577,   182,   962, -1202, -1474,  1468,
      573, -1325,   264,   383,  -829,  1458, -1602,  -130,
     -681,  1017,   732,   608, -1542,   411,  -205, -1571,
     1223,   652,  -552,  1015, -1293,  1491,  -282, -1544,
      516,    -8,  -320,  -666, -1618, -1162,   126,  1469,
     -853,   -90,  -271,   830,   107, -1421,  -247,  -951,
     -398,   961, -1508,  -725,   448, -1065,   677, -1275,
    // upper half holds the basemul twiddles, read as 64 + i
    -1103,   430,   555,   843, -1251,   871,  1550,   105,
      422,   587,   177,  -235,  -291,  -460,  1574,  1653,
     -246,   778,  1159,  -147,  -777,  1483,  -602,  1119,
    -1590,   644,  -872,   349,   418,   329,  -156,   -75,
      817,  1097,   603,   610,  1322, -1285, -1465,   384,
    -1215,  -136,  1218, -1335,  -874,   220, -1187, -1659,
    -1185, -1530, -1278,   794, -1510,  -854,  -870,   478,
     -108,  -308,   996,   991,   958, -1460,  1522,  1628
  };

  // registered output so the table maps onto block ROM
  always_ff @(posedge clk) begin
    zeta <= zeta_table[addr];
  end

endmodule

//--- fq_mul.sv
// Montgomery product x*y*2^-16 mod q, result in (-q, q), operands must fit int16
`include "kyber_consts.svh"

module fq_mul (
  input  logic              clk,
  input  kyber_pkg::coeff_t x,
  input  kyber_pkg::coeff_t y,
  output kyber_pkg::coeff_t r
);

  import kyber_pkg::*;

  prod_t  prod_q;
  prod_t  t_mul;
  coeff_t t;
  prod_t  diff;

  // stage 1: full signed product
  always_ff @(posedge clk) begin
    prod_q <= prod_t'(x) * prod_t'(y);
  end

  // t = low half of prod * qinv, kept signed
  // prod - t*q has a zero low half, so the upper half is the reduced value
  always_comb begin
    t_mul = prod_q * prod_t'(`KYBER_QINV);
    t     = t_mul[`KYBER_POLY_WIDTH-1:0];
    diff  = prod_q - prod_t'(t) * prod_t'(`KYBER_Q);
  end

  // stage 2
  always_ff @(posedge clk) begin
    r <= diff[2*`KYBER_POLY_WIDTH-1:`KYBER_POLY_WIDTH];
  end

endmodule

//--- basemul.sv
// degree-one product mod (X^2 - zeta), fixed latency, accepts one pair per cycle, no stall
`include "kyber_consts.svh"

module basemul (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  kyber_pkg::coeff_pair_u a,
  input  kyber_pkg::coeff_pair_u b,
  input  kyber_pkg::coeff_t      zeta,
  output logic                   out_valid,
  output kyber_pkg::coeff_pair_u r
);

  import kyber_pkg::*;

  localparam int dly = `KYBER_FQMUL_LAT;

  coeff_t p11;
  coeff_t p00;
  coeff_t p01;
  coeff_t p10;
  coeff_t pz;

  coeff_t zeta_d [dly];
  coeff_t p00_d [dly];
  coeff_t p01_d [dly];
  coeff_t p10_d [dly];

  logic [`KYBER_BASEMUL_LAT-1:0] valid_sr;

  // first rank, all four cross products
  fq_mul u_mul_11 (.clk(clk), .x(a.pair.hi), .y(b.pair.hi), .r(p11));
  fq_mul u_mul_00 (.clk(clk), .x(a.pair.lo), .y(b.pair.lo), .r(p00));
  fq_mul u_mul_01 (.clk(clk), .x(a.pair.lo), .y(b.pair.hi), .r(p01));
  fq_mul u_mul_10 (.clk(clk), .x(a.pair.hi), .y(b.pair.lo), .r(p10));

  // second rank, a1*b1 times zeta
  fq_mul u_mul_z (.clk(clk), .x(p11), .y(zeta_d[dly-1]), .r(pz));

  // zeta waits for the first rank, the other products wait for the second
  always_ff @(posedge clk) begin
    zeta_d[0] <= zeta;
    p00_d[0]  <= p00;
    p01_d[0]  <= p01;
    p10_d[0]  <= p10;
    for (int k = 1; k < dly; k++) begin
      zeta_d[k] <= zeta_d[k-1];
      p00_d[k]  <= p00_d[k-1];
      p01_d[k]  <= p01_d[k-1];
      p10_d[k]  <= p10_d[k-1];
    end
  end

  // sums stay within (-2q, 2q), no overflow in 16 bits
  always_comb begin
    r.pair.lo = pz + p00_d[dly-1];
    r.pair.hi = p01_d[dly-1] + p10_d[dly-1];
  end

  // one bit per item in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[`KYBER_BASEMUL_LAT-2:0], in_valid};
    end
  end

  assign out_valid = valid_sr[`KYBER_BASEMUL_LAT-1];

  // operands below q in magnitude keep both results inside (-2q, 2q)
  a_out_range : assert property (
    @(posedge clk) disable iff (reset)
    out_valid |-> (r.pair.lo > coeff_t'(-2 * `KYBER_Q))
                  && (r.pair.lo < coeff_t'(2 * `KYBER_Q))
                  && (r.pair.hi > coeff_t'(-2 * `KYBER_Q))
                  && (r.pair.hi < coeff_t'(2 * `KYBER_Q))
  );

endmodule

//--- coeff_ram.sv
// 128 coefficient pairs, two write and two read ports, reads return one cycle later
module coeff_ram (
  input  logic                   clk,
  input  logic                   we,
  input  logic [6:0]             waddr,
  input  kyber_pkg::coeff_pair_u wdata,
  input  logic                   we1,
  input  logic [6:0]             waddr1,
  input  kyber_pkg::coeff_pair_u wdata1,
  input  logic [6:0]             raddr0,
  input  logic [6:0]             raddr1,
  output kyber_pkg::coeff_pair_u rdata0,
  output kyber_pkg::coeff_pair_u rdata1
);

  import kyber_pkg::*;

  coeff_pair_u mem [128];

  // second write port only used by the result RAM
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    if (we1) begin
      mem[waddr1] <= wdata1;
    end
  end

  always_ff @(posedge clk) begin
    rdata0 <= mem[raddr0];
    rdata1 <= mem[raddr1];
  end

  // the lanes always write an even and an odd word, never the same one
  a_no_write_clash : assert property (
    @(posedge clk) (we && we1) |-> (waddr != waddr1)
  );

endmodule

//--- poly_basemul_montgomery.sv
// NTT-domain pointwise multiply only; load and read back while idle, start ignored when busy
`include "kyber_consts.svh"

module poly_basemul_montgomery (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic        load_we,
  input  logic        load_sel,
  input  logic [6:0]  load_addr,
  input  logic [31:0] load_data,
  input  logic [6:0]  rd_addr,
  output logic        busy,
  output logic        done,
  output logic [31:0] rd_data
);

  import kyber_pkg::*;

  // sequencer state
  logic       issue;
  logic       issue_d;
  logic [5:0] iter;
  logic [6:0] run_cnt;
  logic       accept;

  // write index travelling with the lanes
  logic [5:0] idx_pipe [`KYBER_BASEMUL_LAT+1];

  coeff_pair_u load_word;
  coeff_pair_u a_word0;
  coeff_pair_u a_word1;
  coeff_pair_u b_word0;
  coeff_pair_u b_word1;
  coeff_pair_u res0;
  coeff_pair_u res1;
  coeff_pair_u rd_word;

  logic [6:0] rom_addr;
  coeff_t     zeta;
  coeff_t     zeta_neg;
  logic       res0_valid;
  logic       res1_valid;
  logic [6:0] res0_addr;
  logic [6:0] res1_addr;

  assign accept = start && !busy;

  always_comb begin
    load_word.raw = load_data;
  end

  // busy covers cycles 1..69, done pulses in cycle 70
  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      run_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        busy    <= 1'b1;
        run_cnt <= 7'd1;
      end else if (busy) begin
        run_cnt <= run_cnt + 7'd1;
        if (run_cnt == 7'(`KYBER_RUN_LAT - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // one iteration per cycle, issue high in cycles 1..64
  always_ff @(posedge clk) begin
    if (reset) begin
      issue   <= 1'b0;
      issue_d <= 1'b0;
      iter    <= '0;
    end else begin
      issue_d <= issue;
      if (accept) begin
        issue <= 1'b1;
        iter  <= '0;
      end else if (issue) begin
        iter <= iter + 6'd1;
        if (iter == 6'(`KYBER_ITER - 1)) begin
          issue <= 1'b0;
        end
      end
    end
  end

  // idx_pipe[0] lines up with the lane input, the last stage with the lane output
  always_ff @(posedge clk) begin
    idx_pipe[0] <= iter;
    for (int k = 1; k <= `KYBER_BASEMUL_LAT; k++) begin
      idx_pipe[k] <= idx_pipe[k-1];
    end
  end

  assign rom_addr = 7'(`KYBER_ITER + iter);

  // lane 1 uses the negated twiddle
  assign zeta_neg = -zeta;

  // input RAMs: the load path writes, port 0 feeds lane 0, port 1 feeds lane 1
  coeff_ram ram_a (
    .clk    (clk),
    .we     (load_we && !load_sel && !busy),
    .waddr  (load_addr),
    .wdata  (load_word),
    .we1    (1'b0),
    .waddr1 (7'd0),
    .wdata1 ('0),
    .raddr0 ({iter, 1'b0}),
    .raddr1 ({iter, 1'b1}),
    .rdata0 (a_word0),
    .rdata1 (a_word1)
  );

  coeff_ram ram_b (
    .clk    (clk),
    .we     (load_we && load_sel && !busy),
    .waddr  (load_addr),
    .wdata  (load_word),
    .we1    (1'b0),
    .waddr1 (7'd0),
    .wdata1 ('0),
    .raddr0 ({iter, 1'b0}),
    .raddr1 ({iter, 1'b1}),
    .rdata0 (b_word0),
    .rdata1 (b_word1)
  );

  rom_zetas u_rom_zetas (
    .clk  (clk),
    .addr (rom_addr),
    .zeta (zeta)
  );

  basemul u_lane0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (issue_d),
    .a         (a_word0),
    .b         (b_word0),
    .zeta      (zeta),
    .out_valid (res0_valid),
    .r         (res0)
  );

  basemul u_lane1 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (issue_d),
    .a         (a_word1),
    .b         (b_word1),
    .zeta      (zeta_neg),
    .out_valid (res1_valid),
    .r         (res1)
  );

  assign res0_addr = {idx_pipe[`KYBER_BASEMUL_LAT], 1'b0};
  assign res1_addr = {idx_pipe[`KYBER_BASEMUL_LAT], 1'b1};

  // result RAM, host reads through port 0; port 1 has no reader
  coeff_ram ram_r (
    .clk    (clk),
    .we     (res0_valid),
    .waddr  (res0_addr),
    .wdata  (res0),
    .we1    (res1_valid),
    .waddr1 (res1_addr),
    .wdata1 (res1),
    .raddr0 (rd_addr),
    .raddr1 (rd_addr),
    .rdata0 (rd_word),
    .rdata1 ()
  );

  assign rd_data = rd_word.raw;

  // a start during a run would be dropped silently
  a_start_idle : assert property (
    @(posedge clk) disable iff (reset) start |-> !busy
  );

endmodule

//--- tb_poly_basemul.sv
// self-checking directed tests with a software basemul model; assumes the fixed Kyber q and n
`include "kyber_consts.svh"

module tb_poly_basemul;

  import kyber_pkg::*;

  localparam int words = `KYBER_WORDS;
  // one test loads both polynomials, runs once and reads back twice at most
  localparam int run_cycles = 2 * words + `KYBER_RUN_LAT + 2 * (words + 1);
  localparam int watchdog_cycles = 16 + 20 * run_cycles;

  logic        clk;
  logic        reset;
  logic        start;
  logic        load_we;
  logic        load_sel;
  logic [6:0]  load_addr;
  logic [31:0] load_data;
  logic [6:0]  rd_addr;
  logic        busy;
  logic        done;
  logic [31:0] rd_data;

  int          a_coef [`KYBER_N];
  int          b_coef [`KYBER_N];
  int          zeta_ref [words];
  logic [31:0] exp_word [words];
  logic [31:0] lfsr_state;
  int          errors;
  int          tests_run;
  int          tests_failed;

  poly_basemul_montgomery dut (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .load_we   (load_we),
    .load_sel  (load_sel),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_addr   (rd_addr),
    .busy      (busy),
    .done      (done),
    .rd_data   (rd_data)
  );

  always #4 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  // uniform enough over [-(q-1), q-1]
  task automatic rand_coeff(output int c);
    int v;
    take_bits(16, v);
    c = v % (2 * `KYBER_Q - 1) - (`KYBER_Q - 1);
  endtask

  function automatic int bit_reverse7(int k);
    int r;
    r = 0;
    for (int b = 0; b < 7; b++) begin
      r = r | (((k >> b) & 1) << (6 - b));
    end
    return r;
  endfunction

  function automatic int pow_mod(int base, int e);
    int r;
    r = 1;
    for (int k = 0; k < e; k++) begin
      r = (r * base) % `KYBER_Q;
    end
    return r;
  endfunction

  // 17^brv7(k) in Montgomery form, centred into (-q/2, q/2]
  task automatic build_zetas;
    int v;
    for (int k = 0; k < words; k++) begin
      v = (pow_mod(17, bit_reverse7(k)) * 65536) % `KYBER_Q;
      if (v > `KYBER_Q / 2) begin
        v = v - `KYBER_Q;
      end
      zeta_ref[k] = v;
    end
  endtask

  // montgomery reduction of x*y: t = low half of p*qinv, result = high half of p - t*q
  function automatic int fq_ref(int x, int y);
    int               p;
    int               pq;
    logic signed [15:0] t;
    p  = x * y;
    pq = p * `KYBER_QINV;
    t  = pq[15:0];
    return (p - int'(t) * `KYBER_Q) >>> 16;
  endfunction

  function automatic logic [31:0] pack_pair(int lo, int hi);
    logic [31:0] w;
    w = {hi[15:0], lo[15:0]};
    return w;
  endfunction

  task automatic compute_model;
    int z;
    int r0;
    int r1;
    for (int k = 0; k < words; k++) begin
      z = zeta_ref[`KYBER_ITER + k / 2];
      // odd words belong to lane 1, which twists by -zeta
      if (k % 2 == 1) begin
        z = -z;
      end
      r0 = fq_ref(fq_ref(a_coef[2*k+1], b_coef[2*k+1]), z) + fq_ref(a_coef[2*k], b_coef[2*k]);
      r1 = fq_ref(a_coef[2*k], b_coef[2*k+1]) + fq_ref(a_coef[2*k+1], b_coef[2*k]);
      exp_word[k] = pack_pair(r0, r1);
    end
  endtask

  task automatic write_word(input logic sel, input int addr, input logic [31:0] data);
    load_we   = 1'b1;
    load_sel  = sel;
    load_addr = 7'(addr);
    load_data = data;
    @(posedge clk);
    #1;
    load_we = 1'b0;
  endtask

  task automatic load_polys;
    for (int k = 0; k < words; k++) begin
      write_word(1'b0, k, pack_pair(a_coef[2*k], a_coef[2*k+1]));
    end
    for (int k = 0; k < words; k++) begin
      write_word(1'b1, k, pack_pair(b_coef[2*k], b_coef[2*k+1]));
    end
  endtask

  // cycles counts from the start cycle, so done in cycle 70 gives 70
  task automatic run_and_wait(output int cycles);
    start = 1'b1;
    @(posedge clk);
    #1;
    start   = 1'b0;
    // any load paired with start lands at the same edge
    load_we = 1'b0;
    cycles  = 1;
    if (!busy) begin
      $display("busy did not rise after start at %0t", $time);
      errors++;
    end
    while (!done && cycles < 2 * `KYBER_RUN_LAT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      $display("timeout at %0t: done never pulsed", $time);
      errors++;
    end else if (busy) begin
      $display("busy still high while done pulses at %0t", $time);
      errors++;
    end
  endtask

  // address n goes out first, then rd_data must still hold the word for address n-1
  task automatic read_check(input bit descending);
    int prev;
    int last;
    prev = -1;
    for (int n = 0; n <= words; n++) begin
      last = prev;
      if (n < words) begin
        prev    = descending ? words - 1 - n : n;
        rd_addr = 7'(prev);
      end
      #1;
      if (last >= 0 && rd_data !== exp_word[last]) begin
        $display("mismatch at %0t: rd_data[%0d] expected %h got %h",
                 $time, last, exp_word[last], rd_data);
        errors++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic check_latency(input int cycles);
    if (cycles != `KYBER_RUN_LAT) begin
      $display("mismatch at %0t: done latency expected %0d got %0d",
               $time, `KYBER_RUN_LAT, cycles);
      errors++;
    end
  endtask

  task automatic reset_and_zero;
    int err_start;
    int cycles;
    err_start = errors;
    if (busy !== 1'b0 || done !== 1'b0) begin
      $display("busy or done not low after reset at %0t", $time);
      errors++;
    end
    for (int k = 0; k < `KYBER_N; k++) begin
      a_coef[k] = 0;
      b_coef[k] = 0;
    end
    load_polys();
    compute_model();
    run_and_wait(cycles);
    check_latency(cycles);
    read_check(1'b0);
    report_test("reset_and_zero", err_start);
  endtask

  task automatic all_ones;
    int err_start;
    int cycles;
    err_start = errors;
    for (int k = 0; k < `KYBER_N; k++) begin
      a_coef[k] = 1;
      b_coef[k] = 1;
    end
    load_polys();
    compute_model();
    run_and_wait(cycles);
    read_check(1'b0);
    report_test("all_ones", err_start);
  endtask

  task automatic random_operands;
    int err_start;
    int cycles;
    err_start = errors;
    for (int k = 0; k < `KYBER_N; k++) begin
      rand_coeff(a_coef[k]);
      rand_coeff(b_coef[k]);
    end
    load_polys();
    compute_model();
    run_and_wait(cycles);
    read_check(1'b0);
    report_test("random_operands", err_start);
  endtask

  // second start the cycle done falls, with word 0 of a and b replaced in between
  task automatic back_to_back;
    int err_start;
    int cycles;
    err_start = errors;
    for (int k = 0; k < `KYBER_N; k++) begin
      rand_coeff(a_coef[k]);
      rand_coeff(b_coef[k]);
    end
    load_polys();
    run_and_wait(cycles);
    rand_coeff(a_coef[0]);
    rand_coeff(a_coef[1]);
    rand_coeff(b_coef[0]);
    rand_coeff(b_coef[1]);
    compute_model();
    write_word(1'b0, 0, pack_pair(a_coef[0], a_coef[1]));
    if (done) begin
      $display("done longer than one cycle at %0t", $time);
      errors++;
    end
    load_we   = 1'b1;
    load_sel  = 1'b1;
    load_addr = 7'd0;
    load_data = pack_pair(b_coef[0], b_coef[1]);
    run_and_wait(cycles);
    check_latency(cycles);
    read_check(1'b0);
    report_test("back_to_back", err_start);
  endtask

  task automatic extreme_values;
    int err_start;
    int cycles;
    int s;
    err_start = errors;
    for (int k = 0; k < `KYBER_N; k++) begin
      take_bits(1, s);
      a_coef[k] = s ? `KYBER_Q - 1 : 1 - `KYBER_Q;
      take_bits(1, s);
      b_coef[k] = s ? `KYBER_Q - 1 : 1 - `KYBER_Q;
    end
    load_polys();
    compute_model();
    run_and_wait(cycles);
    read_check(1'b0);
    report_test("extreme_values", err_start);
  endtask

  // results of the previous run, read up and then down
  task automatic read_latency;
    int err_start;
    err_start = errors;
    read_check(1'b0);
    read_check(1'b1);
    report_test("read_latency", err_start);
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    load_we      = 1'b0;
    load_sel     = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    rd_addr      = '0;
    lfsr_state   = 32'hf7d4715d;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    build_zetas();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_and_zero();
    all_ones();
    random_operands();
    back_to_back();
    extreme_values();
    read_latency();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
kyber_pkg.sv
rom_zetas.sv
fq_mul.sv
basemul.sv
coeff_ram.sv
poly_basemul_montgomery.sv
tb_poly_basemul.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_poly_basemul
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
